//--- common/zbus_pkg.sv
// Sound bus is byte wide with a 15-bit address; sound RAM region decode assumes 8 KB max
package zbus_pkg;

	// ----------------------------------------------------------------------
	// Widths
	// ----------------------------------------------------------------------
	localparam int ZBUS_AW = 15;

	typedef logic [7:0] zbyte_t;

	// Bank register holds main-bus address bits 23..15
	typedef logic [8:0] bank_t;

	// ----------------------------------------------------------------------
	// Address word, decoded two ways
	// ----------------------------------------------------------------------
	typedef struct packed {
		logic [1:0]         region;
		logic [ZBUS_AW-3:0] offset;
	} zbus_ram_view_t;

	typedef struct packed {
		logic [6:0] page;
		logic [7:0] low;
	} zbus_page_view_t;

	// RAM / FM windows use the ram view, register pages use the page view
	typedef union packed {
		zbus_ram_view_t  ram;
		zbus_page_view_t page;
	} zbus_addr_u;

	// Who issued the access
	typedef enum logic {
		ZSRC_MAIN = 1'b0,
		ZSRC_Z80  = 1'b1
	} zsrc_e;

	// ----------------------------------------------------------------------
	// Bus constants
	// ----------------------------------------------------------------------
	localparam zbyte_t OPEN_BUS = 8'hFF;

	// 6000-60FF
	localparam logic [6:0] BANK_PAGE = 7'h60;

	// 4000-5FFF, FM chip window (not implemented, reads open bus)
	localparam logic [1:0] FM_REGION = 2'b10;

endpackage

//--- rtl/zbus_arbiter.sv
// Main side wins ties; a side is eligible only while its ack is low; one access at a time
module zbus_arbiter
	import zbus_pkg::*;
(
	input  logic       MCLK,
	input  logic       reset,

	input  logic       m_sel,
	input  zbus_addr_u m_addr,
	input  logic       m_we,
	input  zbyte_t     m_wdata,

	input  logic       z_sel,
	input  zbus_addr_u z_addr,
	input  logic       z_we,
	input  zbyte_t     z_wdata,

	input  logic       m_ack,
	input  logic       z_ack,

	output logic       acc_go,
	output zbus_addr_u acc_addr,
	output logic       acc_we,
	output zbyte_t     acc_wdata,
	output zsrc_e      acc_src
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ACCESS,
		ST_WAIT
	} arb_state_e;

	arb_state_e state;

	logic m_pend;
	logic z_pend;

	// A side that already holds its ack is not served again
	assign m_pend = m_sel & ~m_ack;
	assign z_pend = z_sel & ~z_ack;

	// ----------------------------------------------------------------------
	// Sequencer
	// ----------------------------------------------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			state  <= ST_IDLE;
			acc_go <= 1'b0;
		end else begin
			acc_go <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (m_pend || z_pend) begin
						acc_go <= 1'b1;
						state  <= ST_ACCESS;
					end
				end
				ST_ACCESS: state <= ST_WAIT;
				// Target answers now, reply raises ack next cycle
				ST_WAIT:   state <= ST_IDLE;
				default:   state <= ST_IDLE;
			endcase
		end
	end

	// Request capture, held until the next acc_go
	always_ff @(posedge MCLK) begin
		if (state == ST_IDLE) begin
			if (m_pend) begin
				acc_addr  <= m_addr;
				acc_we    <= m_we;
				acc_wdata <= m_wdata;
				acc_src   <= ZSRC_MAIN;
			end else if (z_pend) begin
				acc_addr  <= z_addr;
				acc_we    <= z_we;
				acc_wdata <= z_wdata;
				acc_src   <= ZSRC_Z80;
			end
		end
	end

	// ----------------------------------------------------------------------
	// Checks
	// ----------------------------------------------------------------------
	a_go_single: assert property (@(posedge MCLK) disable iff (reset)
		acc_go |=> !acc_go);

	a_go_in_access: assert property (@(posedge MCLK) disable iff (reset)
		acc_go |-> state == ST_ACCESS);

endmodule

//--- rtl/zbus_target.sv
// RAM_AW up to 13; RAM mirrors below 4000; main side needs bus_req and z80_run to touch anything
module zbus_target
	import zbus_pkg::*;
#(
	parameter int RAM_AW = 13
) (
	input  logic       MCLK,
	input  logic       reset,

	input  logic       acc_go,
	input  zbus_addr_u acc_addr,
	input  logic       acc_we,
	input  zbyte_t     acc_wdata,
	input  zsrc_e      acc_src,

	input  logic       bus_req,
	input  logic       z80_run,

	output logic       rd_valid,
	output zbyte_t     rd_data,
	output zsrc_e      rd_src,
	output bank_t      bank
);

	zbyte_t ram [0:(1 << RAM_AW) - 1];
	zbyte_t ram_q;

	logic bus_free;
	logic access_ok;
	logic ram_sel;
	logic bank_sel;
	logic fm_sel;
	logic ram_we;
	logic bank_we;
	logic rd_open;

	// Main CPU owns the sound bus and the Z80 is running
	assign bus_free  = bus_req & z80_run;
	assign access_ok = (acc_src == ZSRC_Z80) | bus_free;

	// 0000-3FFF RAM, 6000-60FF bank page, 4000-5FFF FM window (dropped)
	assign ram_sel  = ~acc_addr.ram.region[1];
	assign bank_sel = acc_addr.page.page == BANK_PAGE;
	assign fm_sel   = acc_addr.ram.region == FM_REGION;

	assign ram_we  = acc_go & acc_we & access_ok & ram_sel;
	assign bank_we = acc_go & acc_we & access_ok & bank_sel;

	// ----------------------------------------------------------------------
	// Sound RAM, one-cycle read
	// ----------------------------------------------------------------------
	always_ff @(posedge MCLK) begin
		if (ram_we)
			ram[acc_addr.ram.offset[RAM_AW-1:0]] <= acc_wdata;
		ram_q <= ram[acc_addr.ram.offset[RAM_AW-1:0]];
	end

	// Bank register, data bit 0 shifts in at the top
	always_ff @(posedge MCLK) begin
		if (reset)
			bank <= '0;
		else if (bank_we)
			bank <= {acc_wdata[0], bank[8:1]};
	end

	// ----------------------------------------------------------------------
	// Read return
	// ----------------------------------------------------------------------
	always_ff @(posedge MCLK) begin
		if (reset)
			rd_valid <= 1'b0;
		else
			rd_valid <= acc_go;
	end

	always_ff @(posedge MCLK) begin
		if (acc_go) begin
			rd_src  <= acc_src;
			rd_open <= fm_sel | ~ram_sel | ~access_ok;
		end
	end

	assign rd_data = rd_open ? OPEN_BUS : ram_q;

	// Main side without the bus leaves the addressed RAM byte as it was
	a_main_wr_needs_bus: assert property (@(posedge MCLK) disable iff (reset)
		(acc_go && acc_src == ZSRC_MAIN && !bus_free)
		|=> ram[acc_addr.ram.offset[RAM_AW-1:0]] === ram_q);

endmodule

//--- rtl/zbus_reply.sv
// Ack rises one cycle after rd_valid and falls one cycle after that side's select is seen low
module zbus_reply
	import zbus_pkg::*;
(
	input  logic   MCLK,
	input  logic   reset,

	input  logic   rd_valid,
	input  zbyte_t rd_data,
	input  zsrc_e  rd_src,

	input  logic   m_sel,
	input  logic   z_sel,

	output zbyte_t m_rdata,
	output logic   m_ack,
	output zbyte_t z_rdata,
	output logic   z_ack
);

	logic m_done;
	logic z_done;

	assign m_done = rd_valid & (rd_src == ZSRC_MAIN);
	assign z_done = rd_valid & (rd_src == ZSRC_Z80);

	// ----------------------------------------------------------------------
	// Acknowledge levels
	// ----------------------------------------------------------------------
	always_ff @(posedge MCLK) begin
		if (reset) begin
			m_ack <= 1'b0;
			z_ack <= 1'b0;
		end else begin
			// Master dropped its select, release the ack
			if (!m_sel)
				m_ack <= 1'b0;
			if (!z_sel)
				z_ack <= 1'b0;

			if (m_done)
				m_ack <= 1'b1;
			if (z_done)
				z_ack <= 1'b1;
		end
	end

	// Read data, held until the next access for that side
	always_ff @(posedge MCLK) begin
		if (m_done)
			m_rdata <= rd_data;
		if (z_done)
			z_rdata <= rd_data;
	end

	a_one_ack_rise: assert property (@(posedge MCLK) disable iff (reset)
		!($rose(m_ack) && $rose(z_ack)));

endmodule

//--- rtl/zbus_top.sv
// One access in flight; fixed 3-cycle select-to-ack latency; masters hold select until ack
module zbus_top
	import zbus_pkg::*;
#(
	parameter int RAM_AW = 13
) (
	input  logic       MCLK,
	input  logic       reset,

	// Main CPU side, A00000 window
	input  logic       m_sel,
	input  zbus_addr_u m_addr,
	input  logic       m_we,
	input  zbyte_t     m_wdata,
	output zbyte_t     m_rdata,
	output logic       m_ack,

	// Z80 side, below 8000
	input  logic       z_sel,
	input  zbus_addr_u z_addr,
	input  logic       z_we,
	input  zbyte_t     z_wdata,
	output zbyte_t     z_rdata,
	output logic       z_ack,

	input  logic       bus_req,
	input  logic       z80_run,
	output bank_t      bank
);

	logic       acc_go;
	zbus_addr_u acc_addr;
	logic       acc_we;
	zbyte_t     acc_wdata;
	zsrc_e      acc_src;

	logic       rd_valid;
	zbyte_t     rd_data;
	zsrc_e      rd_src;

	zbus_arbiter u_arbiter (
		.MCLK      (MCLK),
		.reset     (reset),
		.m_sel     (m_sel),
		.m_addr    (m_addr),
		.m_we      (m_we),
		.m_wdata   (m_wdata),
		.z_sel     (z_sel),
		.z_addr    (z_addr),
		.z_we      (z_we),
		.z_wdata   (z_wdata),
		.m_ack     (m_ack),
		.z_ack     (z_ack),
		.acc_go    (acc_go),
		.acc_addr  (acc_addr),
		.acc_we    (acc_we),
		.acc_wdata (acc_wdata),
		.acc_src   (acc_src)
	);

	zbus_target #(
		.RAM_AW (RAM_AW)
	) u_target (
		.MCLK      (MCLK),
		.reset     (reset),
		.acc_go    (acc_go),
		.acc_addr  (acc_addr),
		.acc_we    (acc_we),
		.acc_wdata (acc_wdata),
		.acc_src   (acc_src),
		.bus_req   (bus_req),
		.z80_run   (z80_run),
		.rd_valid  (rd_valid),
		.rd_data   (rd_data),
		.rd_src    (rd_src),
		.bank      (bank)
	);

	zbus_reply u_reply (
		.MCLK     (MCLK),
		.reset    (reset),
		.rd_valid (rd_valid),
		.rd_data  (rd_data),
		.rd_src   (rd_src),
		.m_sel    (m_sel),
		.z_sel    (z_sel),
		.m_rdata  (m_rdata),
		.m_ack    (m_ack),
		.z_rdata  (z_rdata),
		.z_ack    (z_ack)
	);

endmodule

//--- bench/zbus_checks.svh
// Included inside zbus_tb; uses its errors, checks and per-test counters
`ifndef ZBUS_CHECKS_SVH
`define ZBUS_CHECKS_SVH

// ----------------------------------------------------------------------
// Compare tasks
// ----------------------------------------------------------------------
task automatic check_byte(input string name, input zbyte_t exp, input zbyte_t act);
	checks++;
	if (act !== exp) begin
		errors++;
		$display("MISMATCH t=%0t %s expected %h got %h", $time, name, exp, act);
	end
endtask

task automatic check_bank(input string name, input bank_t exp, input bank_t act);
	checks++;
	if (act !== exp) begin
		errors++;
		$display("MISMATCH t=%0t %s expected %h got %h", $time, name, exp, act);
	end
endtask

// Cycle counts from the drive edge to the sampled ack
task automatic check_cycles(input string name, input int exp, input int act);
	checks++;
	if (act != exp) begin
		errors++;
		$display("MISMATCH t=%0t %s expected %0d got %0d", $time, name, exp, act);
	end
endtask

task automatic report_error(input string msg);
	checks++;
	errors++;
	$display("ERROR t=%0t %s", $time, msg);
endtask

// ----------------------------------------------------------------------
// Per-test reporting
// ----------------------------------------------------------------------
task automatic begin_test(input string name);
	cur_test     = name;
	err_at_start = errors;
	chk_at_start = checks;
endtask

task automatic end_test();
	$display("test %s: %0d checks, %0d errors", cur_test,
		checks - chk_at_start, errors - err_at_start);
endtask

`endif

//--- bench/zbus_tb.sv
// Single-master tests check the idle latency; RAM model covers a 13-bit offset only
module zbus_tb
	import zbus_pkg::*;
();

	localparam int CLK_PERIOD = 20;
	localparam int N_RAM      = 300;
	localparam int N_SHARED   = 120;
	localparam int N_NOBUS    = 150;
	localparam int N_BANK     = 60;
	localparam int N_ACCESSES = N_RAM + 2 * N_SHARED + N_NOBUS + N_BANK + 2;
	// Drive edge to sampled ack, arbiter idle
	localparam int LAT_IDLE   = 4;

	logic       MCLK;
	logic       reset;
	logic       m_sel, m_we, m_ack;
	logic       z_sel, z_we, z_ack;
	logic       bus_req, z80_run;
	zbus_addr_u m_addr, z_addr;
	zbyte_t     m_wdata, m_rdata, z_wdata, z_rdata;
	bank_t      bank;

	zbyte_t     mem_m [0:8191];
	bank_t      bank_m;
	int         errors, checks, err_at_start, chk_at_start;
	string      cur_test;
	int unsigned seed;

	`include "zbus_checks.svh"

	zbus_top #(.RAM_AW(13)) u_zbus_top (.*);

	initial MCLK = 1'b0;
	always #(CLK_PERIOD / 2) MCLK = ~MCLK;

	// Watchdog, 20 cycles per access is far beyond the worst case
	initial begin
		#(CLK_PERIOD * (N_ACCESSES * 20 + 10));
		$display("Timeout: the tests did not finish within %0d cycles", N_ACCESSES * 20);
		$display("Something failed");
		$finish;
	end

	// Mirror bit 13 plus two offset windows so reads hit earlier writes
	function automatic zbus_addr_u rand_ram_addr(input logic [31:0] r);
		return {1'b0, r[13:12], 3'b000, r[8:0]};
	endfunction

	// ----------------------------------------------------------------------
	// Reference model, updated in ack order
	// ----------------------------------------------------------------------
	task automatic update_model(input zsrc_e src, input zbus_addr_u a, input logic we,
			input zbyte_t wd, input zbyte_t rd);
		zbyte_t exp;
		logic   ok;
		ok  = (src == ZSRC_Z80) || (bus_req && z80_run);
		exp = OPEN_BUS;
		if (ok && !a.ram.region[1]) begin
			if (we)
				mem_m[a.ram.offset] = wd;
			exp = mem_m[a.ram.offset];
		end else if (ok && we && a.page.page == BANK_PAGE) begin
			bank_m = {wd[0], bank_m[8:1]};
			check_bank("bank", bank_m, bank);
		end
		if (!we)
			check_byte(src == ZSRC_MAIN ? "m_rdata" : "z_rdata", exp, rd);
	endtask

	// Call on a rising edge; returns on the edge where the ack is seen low again
	task automatic access(input zsrc_e src, input zbus_addr_u a, input logic we,
			input zbyte_t wd, input int exp_lat);
		int n;
		n = 0;
		if (src == ZSRC_MAIN) begin
			m_sel   <= 1'b1;
			m_addr  <= a;
			m_we    <= we;
			m_wdata <= wd;
		end else begin
			z_sel   <= 1'b1;
			z_addr  <= a;
			z_we    <= we;
			z_wdata <= wd;
		end
		do begin
			@(posedge MCLK);
			n++;
		end while ((src == ZSRC_MAIN ? m_ack : z_ack) !== 1'b1);
		update_model(src, a, we, wd, src == ZSRC_MAIN ? m_rdata : z_rdata);
		if (exp_lat > 0)
			check_cycles(src == ZSRC_MAIN ? "m_ack latency" : "z_ack latency", exp_lat, n);
		if (src == ZSRC_MAIN)
			m_sel <= 1'b0;
		else
			z_sel <= 1'b0;
		do @(posedge MCLK); while ((src == ZSRC_MAIN ? m_ack : z_ack) !== 1'b0);
	endtask

	// ----------------------------------------------------------------------
	// Test sequence
	// ----------------------------------------------------------------------
	initial begin
		logic [31:0] r;
		zbus_addr_u  a;
		errors  = 0;
		checks  = 0;
		bank_m  = '0;
		foreach (mem_m[i])
			mem_m[i] = 'x;
		reset   = 1'b1;
		m_sel   = 1'b0;
		m_addr  = '0;
		m_we    = 1'b0;
		m_wdata = '0;
		z_sel   = 1'b0;
		z_addr  = '0;
		z_we    = 1'b0;
		z_wdata = '0;
		bus_req = 1'b0;
		z80_run = 1'b0;
		seed    = 32'h620;
		void'($urandom(seed));
		repeat (4) @(posedge MCLK);
		reset <= 1'b0;
		@(posedge MCLK);

		begin_test("state after reset");
		if (m_ack !== 1'b0 || z_ack !== 1'b0)
			report_error("an acknowledge is not low after reset");
		check_bank("bank", '0, bank);
		end_test();

		begin_test("z80 ram round trip");
		repeat (N_RAM) begin
			r = $urandom;
			access(ZSRC_Z80, rand_ram_addr(r), r[31] | r[30], r[23:16], LAT_IDLE);
		end
		end_test();

		begin_test("main with bus free");
		bus_req <= 1'b1;
		z80_run <= 1'b1;
		@(posedge MCLK);
		fork
			repeat (N_SHARED) begin
				logic [31:0] rm;
				rm = $urandom;
				access(ZSRC_MAIN, rand_ram_addr(rm), rm[31], rm[23:16], 0);
			end
			repeat (N_SHARED) begin
				logic [31:0] rz;
				rz = $urandom;
				access(ZSRC_Z80, rand_ram_addr(rz), rz[31], rz[23:16], 0);
			end
		join
		end_test();

		begin_test("main without bus");
		repeat (N_NOBUS) begin
			r = $urandom;
			// At least one of the two levels low
			bus_req <= r[24];
			z80_run <= r[24] ? 1'b0 : r[25];
			access(r[26] ? ZSRC_MAIN : ZSRC_Z80, rand_ram_addr(r), r[31], r[23:16], LAT_IDLE);
		end
		end_test();

		begin_test("bank register");
		repeat (N_BANK) begin
			r = $urandom;
			case (r[25:24])
				2'd2:    a = {2'b10, r[12:0]};
				2'd3:    a = {3'b111, r[11:0]};
				default: a = {7'h60, r[7:0]};
			endcase
			access(ZSRC_Z80, a, r[31] | r[30], r[23:16], LAT_IDLE);
		end
		check_bank("bank", bank_m, bank);
		end_test();

		begin_test("latency and arbitration");
		r = $urandom;
		fork
			access(ZSRC_MAIN, rand_ram_addr(r), 1'b0, 8'h00, LAT_IDLE);
			access(ZSRC_Z80, rand_ram_addr(~r), 1'b0, 8'h00, LAT_IDLE + 3);
		join
		end_test();

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

//--- project.f
+incdir+bench
common/zbus_pkg.sv
rtl/zbus_arbiter.sv
rtl/zbus_target.sv
rtl/zbus_reply.sv
rtl/zbus_top.sv
bench/zbus_tb.sv

//--- Bender.yml
package:
  name: zbus

sources:
  - common/zbus_pkg.sv
  - rtl/zbus_arbiter.sv
  - rtl/zbus_target.sv
  - rtl/zbus_reply.sv
  - rtl/zbus_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/zbus_tb.sv
